//--- common/cia_bus_if.sv
/*
 * CIA register bus
 * Decoded host strobes, register address and write data
 */
`timescale 1ns/1ps
`default_nettype none

`include "cia_settings.svh"

interface cia_bus_if;
  import cia_regs_pkg::*;

  logic                   wr;
  logic                   rd;
  cia_reg_e               addr;
  logic [`CIA_DATA_W-1:0] wdata;

  modport host (output wr, rd, addr, wdata);
  modport target (input wr, rd, addr, wdata);

endinterface

`default_nettype wire

//--- common/cia_event_pkg.sv
/*
 * CIA events
 * Interrupt source positions, event vector and TOD time value
 */
`default_nettype none

`include "cia_settings.svh"

package cia_event_pkg;

  typedef enum int unsigned {
    IRQ_TA    = 0,
    IRQ_TB    = 1,
    IRQ_ALARM = 2,
    IRQ_SP    = 3,
    IRQ_FLAG  = 4
  } cia_irq_src_e;

  typedef logic [`CIA_IRQ_SRC_N-1:0] cia_irq_vec_t;

  // BCD, 12 hour
  typedef struct packed {
    logic       pm;
    logic [4:0] hr;
    logic [6:0] min;
    logic [6:0] sec;
    logic [3:0] tenths;
  } cia_tod_t;

endpackage

`default_nettype wire

//--- common/cia_regs_pkg.sv
/*
 * CIA register map
 * Register addresses and the control register A/B layouts
 */
`default_nettype none

package cia_regs_pkg;

  typedef enum logic [3:0] {
    REG_PRA       = 4'h0,
    REG_PRB       = 4'h1,
    REG_DDRA      = 4'h2,
    REG_DDRB      = 4'h3,
    REG_TA_LO     = 4'h4,
    REG_TA_HI     = 4'h5,
    REG_TB_LO     = 4'h6,
    REG_TB_HI     = 4'h7,
    REG_TOD_10THS = 4'h8,
    REG_TOD_SEC   = 4'h9,
    REG_TOD_MIN   = 4'hA,
    REG_TOD_HR    = 4'hB,
    REG_SDR       = 4'hC,
    REG_ICR       = 4'hD,
    REG_CRA       = 4'hE,
    REG_CRB       = 4'hF
  } cia_reg_e;

  typedef struct packed {
    logic tod_in;      // 50 Hz TOD input
    logic sp_mode;
    logic in_mode;     // count CNT edges
    logic force_load;
    logic one_shot;
    logic out_mode;    // toggle on PB6
    logic pb_on;
    logic start;
  } cia_cra_t;

  typedef struct packed {
    logic       alarm;    // TOD writes go to the alarm
    logic [1:0] in_mode;
    logic       force_load;
    logic       one_shot;
    logic       out_mode;
    logic       pb_on;
    logic       start;
  } cia_crb_t;

endpackage

`default_nettype wire

//--- common/cia_settings.svh
/*
 * CIA settings
 * Bus and timer widths, TOD input divisors, interrupt source count
 */
`ifndef CIA_SETTINGS_SVH
`define CIA_SETTINGS_SVH

`define CIA_DATA_W 8
`define CIA_TIMER_W 16

// TOD input pulses per tenth of a second
`define CIA_TOD_DIV_60 6
`define CIA_TOD_DIV_50 5

`define CIA_IRQ_SRC_N 5

`endif

//--- source/cia_host_bus.sv
/*
 * CIA host bus
 * Turns host cycles into register strobes and registers read data
 */
`timescale 1ns/1ps
`default_nettype none

`include "cia_settings.svh"

module cia_host_bus (
  input  logic                            clk,
  input  logic                            int_reset,
  input  logic                            cs_n,
  input  logic                            rw,
  input  logic [3:0]                      rs,
  input  logic [`CIA_DATA_W-1:0]          db_in,
  output logic [`CIA_DATA_W-1:0]          db_out,
  cia_bus_if.host                         bus,
  input  logic [`CIA_DATA_W-1:0]          port_rdata,
  input  logic [`CIA_DATA_W-1:0]          ta_rdata,
  input  logic [`CIA_DATA_W-1:0]          tb_rdata,
  input  logic [`CIA_DATA_W-1:0]          tod_rdata,
  input  logic [`CIA_DATA_W-1:0]          irq_rdata,
  input  logic [1:0][`CIA_DATA_W-1:0]     ctrl_rdata
);
  import cia_regs_pkg::*;

  assign bus.wr    = !cs_n && !rw;
  assign bus.rd    = !cs_n && rw;
  assign bus.addr  = cia_reg_e'(rs);
  assign bus.wdata = db_in;

  // Read data holds until the next read
  always_ff @(posedge clk) begin
    if (int_reset) begin
      db_out <= '0;
    end else if (bus.rd) begin
      case (bus.addr)
        REG_PRA, REG_PRB, REG_DDRA, REG_DDRB:                 db_out <= port_rdata;
        REG_TA_LO, REG_TA_HI:                                 db_out <= ta_rdata;
        REG_TB_LO, REG_TB_HI:                                 db_out <= tb_rdata;
        REG_TOD_10THS, REG_TOD_SEC, REG_TOD_MIN, REG_TOD_HR:  db_out <= tod_rdata;
        REG_ICR:                                              db_out <= irq_rdata;
        REG_CRA, REG_CRB:                                     db_out <= ctrl_rdata[bus.addr[0]];
        default:                                              db_out <= '0;
      endcase
    end
  end

  // One clk per host access
  a_single_cycle_access: assert property (@(posedge clk) disable iff (int_reset)
    (bus.wr || bus.rd) |=> !(bus.wr || bus.rd));

endmodule

`default_nettype wire

//--- source/cia_irq_ctrl.sv
/*
 * CIA interrupt control
 * Event status, set/clear mask and irq_n with clear on read
 */
`timescale 1ns/1ps
`default_nettype none

`include "cia_settings.svh"

module cia_irq_ctrl (
  input  logic                       clk,
  input  logic                       int_reset,
  input  logic                       phi2,
  cia_bus_if.target                  bus,
  input  cia_event_pkg::cia_irq_vec_t events,
  output logic                       irq_n,
  output logic [`CIA_DATA_W-1:0]     irq_rdata
);
  import cia_regs_pkg::*;
  import cia_event_pkg::*;

  cia_irq_vec_t status;
  cia_irq_vec_t mask;
  logic         status_read;

  assign status_read = bus.rd && bus.addr == REG_ICR;

  always_ff @(posedge clk) begin
    if (int_reset) begin
      status <= '0;
      mask   <= '0;
      irq_n  <= 1'b1;
    end else begin
      // Events arriving with the read are kept
      if (status_read)
        status <= events;
      else
        status <= status | events;

      // Bit 7 selects set or clear
      if (bus.wr && bus.addr == REG_ICR) begin
        if (bus.wdata[7])
          mask <= mask | bus.wdata[`CIA_IRQ_SRC_N-1:0];
        else
          mask <= mask & ~bus.wdata[`CIA_IRQ_SRC_N-1:0];
      end

      if (status_read)
        irq_n <= 1'b1;
      else if (phi2 && irq_n)
        irq_n <= !(|(status & mask));
    end
  end

  assign irq_rdata = (bus.addr == REG_ICR)
                   ? {!irq_n, {(`CIA_DATA_W - 1 - `CIA_IRQ_SRC_N){1'b0}}, status}
                   : '0;

  a_irq_has_status: assert property (@(posedge clk) disable iff (int_reset)
    !irq_n |-> |status);

endmodule

`default_nettype wire

//--- source/cia_port_ctrl.sv
/*
 * CIA parallel ports
 * Port A/B data and direction, PB6/PB7 timer outputs, PC strobe, FLAG input
 */
`timescale 1ns/1ps
`default_nettype none

`include "cia_settings.svh"

module cia_port_ctrl (
  input  logic                   clk,
  input  logic                   int_reset,
  input  logic                   phi2,
  cia_bus_if.target              bus,
  input  logic [`CIA_DATA_W-1:0] pa_in,
  input  logic [`CIA_DATA_W-1:0] pb_in,
  input  logic                   flag_n,
  output logic [`CIA_DATA_W-1:0] pa_out,
  output logic [`CIA_DATA_W-1:0] pb_out,
  output logic                   pc_n,
  output logic                   flag_hit,
  output logic [`CIA_DATA_W-1:0] port_rdata,
  input  logic                   ta_pb,
  input  logic                   tb_pb,
  input  logic                   ta_pb_on,
  input  logic                   tb_pb_on
);
  import cia_regs_pkg::*;

  logic [`CIA_DATA_W-1:0] pra;
  logic [`CIA_DATA_W-1:0] prb;
  logic [`CIA_DATA_W-1:0] ddra;
  logic [`CIA_DATA_W-1:0] ddrb;
  logic [`CIA_DATA_W-1:0] pb_pins;
  logic                   flag_prev;

  always_comb begin
    pb_pins = prb | ~ddrb;
    if (ta_pb_on)
      pb_pins[6] = ta_pb;
    if (tb_pb_on)
      pb_pins[7] = tb_pb;
  end

  always_ff @(posedge clk) begin
    if (int_reset) begin
      pra       <= '0;
      prb       <= '0;
      ddra      <= '0;
      ddrb      <= '0;
      pa_out    <= '1;
      pb_out    <= '1;
      pc_n      <= 1'b1;
      flag_prev <= 1'b1;
      flag_hit  <= 1'b0;
    end else begin
      if (bus.wr) begin
        case (bus.addr)
          REG_PRA:  pra  <= bus.wdata;
          REG_PRB:  prb  <= bus.wdata;
          REG_DDRA: ddra <= bus.wdata;
          REG_DDRB: ddrb <= bus.wdata;
          default: ;
        endcase
      end
      if (phi2) begin
        pa_out    <= pra | ~ddra;
        pb_out    <= pb_pins;
        flag_prev <= flag_n;
      end
      // Low for the rest of the phi2 period after a port B access
      if ((bus.wr || bus.rd) && bus.addr == REG_PRB)
        pc_n <= 1'b0;
      else if (phi2)
        pc_n <= 1'b1;
      flag_hit <= phi2 && flag_prev && !flag_n;
    end
  end

  always_comb begin
    case (bus.addr)
      REG_PRA:  port_rdata = pa_in;
      REG_PRB:  port_rdata = pb_in;
      REG_DDRA: port_rdata = ddra;
      REG_DDRB: port_rdata = ddrb;
      default:  port_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/cia_top.sv
/*
 * CIA top level
 * 6526-style interface adapter with ports, two timers, TOD clock and interrupts
 */
`timescale 1ns/1ps
`default_nettype none

`include "cia_settings.svh"

module cia_top (
  input  wire                   clk,
  input  wire                   int_reset,
  input  wire                   phi2,
  input  wire                   cs_n,
  input  wire                   rw,
  input  wire [3:0]             rs,
  input  wire [`CIA_DATA_W-1:0] db_in,
  output wire [`CIA_DATA_W-1:0] db_out,
  input  wire [`CIA_DATA_W-1:0] pa_in,
  output wire [`CIA_DATA_W-1:0] pa_out,
  input  wire [`CIA_DATA_W-1:0] pb_in,
  output wire [`CIA_DATA_W-1:0] pb_out,
  input  wire                   flag_n,
  output wire                   pc_n,
  input  wire                   tod,
  input  wire                   cnt_in,
  output wire                   irq_n
);

  wire [`CIA_DATA_W-1:0]      port_rdata;
  wire [`CIA_DATA_W-1:0]      ta_rdata;
  wire [`CIA_DATA_W-1:0]      tb_rdata;
  wire [`CIA_DATA_W-1:0]      tod_rdata;
  wire [`CIA_DATA_W-1:0]      irq_rdata;
  wire [1:0][`CIA_DATA_W-1:0] ctrl_rdata;
  wire                        ta_underflow;
  wire                        tb_underflow;
  wire                        ta_pb;
  wire                        tb_pb;
  wire                        ta_pb_on;
  wire                        tb_pb_on;
  wire                        tod_50hz;
  wire                        alarm_wr_sel;
  wire                        alarm_hit;
  wire                        flag_hit;

  cia_bus_if bus ();

  cia_host_bus host_bus (
    .clk        (clk),
    .int_reset  (int_reset),
    .cs_n       (cs_n),
    .rw         (rw),
    .rs         (rs),
    .db_in      (db_in),
    .db_out     (db_out),
    .bus        (bus.host),
    .port_rdata (port_rdata),
    .ta_rdata   (ta_rdata),
    .tb_rdata   (tb_rdata),
    .tod_rdata  (tod_rdata),
    .irq_rdata  (irq_rdata),
    .ctrl_rdata (ctrl_rdata)
  );

  cia_port_ctrl port_ctrl (
    .clk        (clk),
    .int_reset  (int_reset),
    .phi2       (phi2),
    .bus        (bus.target),
    .pa_in      (pa_in),
    .pb_in      (pb_in),
    .flag_n     (flag_n),
    .pa_out     (pa_out),
    .pb_out     (pb_out),
    .pc_n       (pc_n),
    .flag_hit   (flag_hit),
    .port_rdata (port_rdata),
    .ta_pb      (ta_pb),
    .tb_pb      (tb_pb),
    .ta_pb_on   (ta_pb_on),
    .tb_pb_on   (tb_pb_on)
  );

  cia_interval_timer #(.TIMER_ID(0)) timer_a (
    .clk            (clk),
    .int_reset      (int_reset),
    .phi2           (phi2),
    .bus            (bus.target),
    .cnt_in         (cnt_in),
    .casc_underflow (1'b0),
    .underflow      (ta_underflow),
    .pb_level       (ta_pb),
    .pb_on          (ta_pb_on),
    .tod_50hz       (tod_50hz),
    .ctrl_rdata     (ctrl_rdata[0]),
    .rdata          (ta_rdata)
  );

  // CRB bit 7 is the alarm write select
  cia_interval_timer #(.TIMER_ID(1)) timer_b (
    .clk            (clk),
    .int_reset      (int_reset),
    .phi2           (phi2),
    .bus            (bus.target),
    .cnt_in         (cnt_in),
    .casc_underflow (ta_underflow),
    .underflow      (tb_underflow),
    .pb_level       (tb_pb),
    .pb_on          (tb_pb_on),
    .tod_50hz       (alarm_wr_sel),
    .ctrl_rdata     (ctrl_rdata[1]),
    .rdata          (tb_rdata)
  );

  cia_tod_clock tod_clock (
    .clk          (clk),
    .int_reset    (int_reset),
    .phi2         (phi2),
    .tod          (tod),
    .alarm_wr_sel (alarm_wr_sel),
    .tod_50hz     (tod_50hz),
    .bus          (bus.target),
    .alarm_hit    (alarm_hit),
    .tod_rdata    (tod_rdata)
  );

  // Serial port source stays quiet
  cia_irq_ctrl irq_ctrl (
    .clk       (clk),
    .int_reset (int_reset),
    .phi2      (phi2),
    .bus       (bus.target),
    .events    ({flag_hit, 1'b0, alarm_hit, tb_underflow, ta_underflow}),
    .irq_n     (irq_n),
    .irq_rdata (irq_rdata)
  );

endmodule

`default_nettype wire

//--- timer/cia_interval_timer.sv
/*
 * CIA interval timer
 * 16-bit down counter with reload latch, one-shot and continuous modes,
 * phi2 / CNT / cascade count sources and a PB output
 */
`timescale 1ns/1ps
`default_nettype none

`include "cia_settings.svh"

module cia_interval_timer #(
  parameter int TIMER_ID = 0
) (
  input  logic                   clk,
  input  logic                   int_reset,
  input  logic                   phi2,
  cia_bus_if.target              bus,
  input  logic                   cnt_in,
  input  logic                   casc_underflow,
  output logic                   underflow,
  output logic                   pb_level,
  output logic                   pb_on,
  output logic                   tod_50hz,
  output logic [`CIA_DATA_W-1:0] ctrl_rdata,
  output logic [`CIA_DATA_W-1:0] rdata
);
  import cia_regs_pkg::*;

  localparam cia_reg_e LO_ADDR = cia_reg_e'((TIMER_ID == 0) ? REG_TA_LO : REG_TB_LO);
  localparam cia_reg_e HI_ADDR = cia_reg_e'((TIMER_ID == 0) ? REG_TA_HI : REG_TB_HI);
  localparam cia_reg_e CR_ADDR = cia_reg_e'((TIMER_ID == 0) ? REG_CRA : REG_CRB);

  logic [`CIA_TIMER_W-1:0] latch;
  logic [`CIA_TIMER_W-1:0] counter;
  logic [`CIA_TIMER_W-1:0] next_val;
  cia_cra_t                cr;
  cia_crb_t                crb_view;
  logic                    cnt_prev;
  logic                    count0;
  logic                    count1;
  logic                    count2;
  logic                    count3;
  logic                    load1;
  logic                    one_shot0;
  logic                    pb_ff;
  logic                    casc_sel;
  logic                    timer_in;

  // Timer B sees bit 6 as the upper half of its count source select
  assign crb_view = cia_crb_t'(cr);
  assign casc_sel = (TIMER_ID == 1) && crb_view.in_mode[1];
  assign timer_in = casc_sel ? casc_underflow && (!crb_view.in_mode[0] || cnt_in)
                             : !crb_view.in_mode[0] || count1;

  // Two-stage start pipeline, count3 enables the decrement
  assign next_val  = count3 ? counter - 1'b1 : counter;
  assign underflow = phi2 && count2 && (next_val == '0);

  always_ff @(posedge clk) begin
    if (int_reset) begin
      latch     <= '1;
      counter   <= '1;
      cr        <= '0;
      cnt_prev  <= 1'b0;
      count0    <= 1'b0;
      count1    <= 1'b0;
      count2    <= 1'b0;
      count3    <= 1'b0;
      load1     <= 1'b0;
      one_shot0 <= 1'b0;
      pb_ff     <= 1'b0;
    end else begin
      if (phi2) begin
        cnt_prev      <= cnt_in;
        count0        <= cnt_in && !cnt_prev;
        count1        <= count0;
        count2        <= timer_in && cr.start;
        count3        <= count2;
        load1         <= cr.force_load;
        cr.force_load <= 1'b0;
        one_shot0     <= cr.one_shot;
        counter       <= next_val;
        if (underflow) begin
          pb_ff   <= !pb_ff;
          counter <= latch;
          count3  <= 1'b0;
          if (cr.one_shot || one_shot0) begin
            cr.start <= 1'b0;
            count2   <= 1'b0;
          end
        end
        if (load1) begin
          counter <= latch;
          count3  <= 1'b0;
        end
      end

      if (bus.wr && bus.addr == LO_ADDR) begin
        latch[`CIA_DATA_W-1:0] <= bus.wdata;
      end else if (bus.wr && bus.addr == HI_ADDR) begin
        latch[`CIA_TIMER_W-1:`CIA_DATA_W] <= bus.wdata;
        // Stopped timer loads at once
        if (!cr.start) begin
          counter <= {bus.wdata, latch[`CIA_DATA_W-1:0]};
          count3  <= 1'b0;
        end
      end else if (bus.wr && bus.addr == CR_ADDR) begin
        cr    <= cia_cra_t'(bus.wdata);
        pb_ff <= pb_ff || (bus.wdata[0] && !cr.start);
        if (!bus.wdata[0])
          count2 <= 1'b0;
      end
    end
  end

  assign pb_level   = cr.out_mode ? pb_ff ^ underflow : underflow;
  assign pb_on      = cr.pb_on;
  assign tod_50hz   = cr.tod_in;
  assign ctrl_rdata = {cr[7:5], 1'b0, cr[3:0]};
  assign rdata      = bus.addr[0] ? counter[`CIA_TIMER_W-1:`CIA_DATA_W]
                                  : counter[`CIA_DATA_W-1:0];

  a_no_underflow_stopped: assert property (@(posedge clk) disable iff (int_reset)
    underflow |-> cr.start);

endmodule

`default_nettype wire

//--- tod/cia_tod_clock.sv
/*
 * CIA time of day clock
 * BCD 12-hour clock from a 50/60 Hz input, with alarm and read latch
 */
`timescale 1ns/1ps
`default_nettype none

`include "cia_settings.svh"

module cia_tod_clock (
  input  logic                   clk,
  input  logic                   int_reset,
  input  logic                   phi2,
  input  logic                   tod,
  input  logic                   alarm_wr_sel,
  input  logic                   tod_50hz,
  cia_bus_if.target              bus,
  output logic                   alarm_hit,
  output logic [`CIA_DATA_W-1:0] tod_rdata
);
  import cia_regs_pkg::*;
  import cia_event_pkg::*;

  localparam cia_tod_t TOD_RESET = '{pm: 1'b0, hr: 5'h01, min: 7'h00, sec: 7'h00,
                                     tenths: 4'h0};

  cia_tod_t   tod_now;
  cia_tod_t   alarm;
  cia_tod_t   latch;
  cia_tod_t   rd_src;
  logic       latched;
  logic       run;
  logic       tod_prev;
  logic [2:0] div_cnt;
  logic [2:0] div_limit;
  logic       alarm_match;
  logic       alarm_eq;
  logic       tod_wr;

  function automatic logic [6:0] bcd_inc59(logic [6:0] v);
    if (v[3:0] != 4'h9)
      return v + 7'h01;
    else if (v[6:4] == 3'h5)
      return 7'h00;
    else
      return {v[6:4] + 3'h1, 4'h0};
  endfunction

  function automatic cia_tod_t tod_next(cia_tod_t t);
    cia_tod_t n;
    n = t;
    if (t.tenths != 4'h9) begin
      n.tenths = t.tenths + 4'h1;
    end else begin
      n.tenths = 4'h0;
      n.sec    = bcd_inc59(t.sec);
      if (t.sec == 7'h59) begin
        n.min = bcd_inc59(t.min);
        if (t.min == 7'h59) begin
          // AM/PM flips going into 12
          if (t.hr == 5'h11)
            n.pm = !t.pm;
          if (t.hr == 5'h12)
            n.hr = 5'h01;
          else if (t.hr == 5'h09)
            n.hr = 5'h10;
          else
            n.hr = t.hr + 5'h01;
        end
      end
    end
    return n;
  endfunction

  function automatic cia_tod_t tod_write(cia_tod_t t, cia_reg_e a,
                                         logic [`CIA_DATA_W-1:0] d);
    cia_tod_t n;
    n = t;
    case (a)
      REG_TOD_10THS: n.tenths = d[3:0];
      REG_TOD_SEC:   n.sec = d[6:0];
      REG_TOD_MIN:   n.min = d[6:0];
      REG_TOD_HR: begin
        n.pm = d[7];
        n.hr = d[4:0];
      end
      default: ;
    endcase
    return n;
  endfunction

  assign div_limit   = tod_50hz ? 3'(`CIA_TOD_DIV_50) : 3'(`CIA_TOD_DIV_60);
  assign alarm_match = (tod_now == alarm);
  assign tod_wr      = bus.wr && (bus.addr inside {REG_TOD_10THS, REG_TOD_SEC,
                                                   REG_TOD_MIN, REG_TOD_HR});

  always_ff @(posedge clk) begin
    if (int_reset) begin
      tod_now   <= TOD_RESET;
      alarm     <= '0;
      latch     <= '0;
      latched   <= 1'b0;
      run       <= 1'b0;
      tod_prev  <= 1'b0;
      div_cnt   <= '0;
      alarm_eq  <= 1'b0;
      alarm_hit <= 1'b0;
    end else begin
      tod_prev  <= tod;
      alarm_hit <= phi2 && alarm_match && !alarm_eq;
      if (phi2)
        alarm_eq <= alarm_match;

      if (!run) begin
        div_cnt <= '0;
      end else if (tod && !tod_prev) begin
        if (div_cnt == div_limit - 3'd1) begin
          div_cnt <= '0;
          tod_now <= tod_next(tod_now);
        end else begin
          div_cnt <= div_cnt + 3'd1;
        end
      end

      // Hours write stops the clock until tenths are written
      if (tod_wr && alarm_wr_sel) begin
        alarm <= tod_write(alarm, bus.addr, bus.wdata);
      end else if (tod_wr) begin
        tod_now <= tod_write(tod_now, bus.addr, bus.wdata);
        if (bus.addr == REG_TOD_10THS)
          run <= 1'b1;
        if (bus.addr == REG_TOD_HR)
          run <= 1'b0;
      end

      if (bus.rd && bus.addr == REG_TOD_HR) begin
        latched <= 1'b1;
        latch   <= tod_now;
      end else if (bus.rd && bus.addr == REG_TOD_10THS) begin
        latched <= 1'b0;
      end
    end
  end

  assign rd_src = latched ? latch : tod_now;

  always_comb begin
    case (bus.addr)
      REG_TOD_10THS: tod_rdata = {4'h0, rd_src.tenths};
      REG_TOD_SEC:   tod_rdata = {1'b0, rd_src.sec};
      REG_TOD_MIN:   tod_rdata = {1'b0, rd_src.min};
      REG_TOD_HR:    tod_rdata = {rd_src.pm, 2'b00, rd_src.hr};
      default:       tod_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- verification/cia_tb.sv
/*
 * CIA testbench
 * Drives the host bus, ports, timers, TOD clock and FLAG of the CIA
 * and compares reads and pins against reference functions
 */
`timescale 1ns/1ps
`default_nettype none

`include "cia_settings.svh"

module cia_tb;
  import cia_regs_pkg::*;
  import cia_event_pkg::*;

  logic                   clk;
  logic                   int_reset;
  logic                   phi2;
  logic                   cs_n;
  logic                   rw;
  logic [3:0]             rs;
  logic [`CIA_DATA_W-1:0] db_in;
  logic [`CIA_DATA_W-1:0] db_out;
  logic [`CIA_DATA_W-1:0] pa_in;
  logic [`CIA_DATA_W-1:0] pa_out;
  logic [`CIA_DATA_W-1:0] pb_in;
  logic [`CIA_DATA_W-1:0] pb_out;
  logic                   flag_n;
  logic                   pc_n;
  logic                   tod;
  logic                   cnt_in;
  logic                   irq_n;

  // Host view of the port registers
  logic [`CIA_DATA_W-1:0] pra_sh;
  logic [`CIA_DATA_W-1:0] prb_sh;
  logic [`CIA_DATA_W-1:0] ddra_sh;
  logic [`CIA_DATA_W-1:0] ddrb_sh;
  int                     mismatch_count;
  int                     fail_count;

  cia_top UUT (
    .clk(clk), .int_reset(int_reset), .phi2(phi2), .cs_n(cs_n), .rw(rw), .rs(rs),
    .db_in(db_in), .db_out(db_out), .pa_in(pa_in), .pa_out(pa_out), .pb_in(pb_in),
    .pb_out(pb_out), .flag_n(flag_n), .pc_n(pc_n), .tod(tod), .cnt_in(cnt_in),
    .irq_n(irq_n)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = !clk;
  end

  // phi2 enable on every second clk
  always @(posedge clk) begin
    #1;
    phi2 = !phi2;
  end

  function automatic logic [`CIA_DATA_W-1:0] port_model(logic [`CIA_DATA_W-1:0] dir,
                                                        logic [`CIA_DATA_W-1:0] data);
    return data | ~dir;
  endfunction

  function automatic logic [`CIA_DATA_W-1:0] irq_model(cia_irq_vec_t status,
                                                       cia_irq_vec_t mask);
    logic [`CIA_DATA_W-1:0] b;
    b = '0;
    b[`CIA_IRQ_SRC_N-1:0] = status;
    b[7] = |(status & mask);
    return b;
  endfunction

  function automatic cia_tod_t bcd_advance(cia_tod_t t);
    cia_tod_t n;
    int tn;
    int s;
    int m;
    int h;
    tn = t.tenths + 1;
    s = t.sec[6:4] * 10 + t.sec[3:0];
    m = t.min[6:4] * 10 + t.min[3:0];
    h = t.hr[4] * 10 + t.hr[3:0];
    n.pm = t.pm;
    if (tn == 10) begin
      tn = 0;
      s = s + 1;
      if (s == 60) begin
        s = 0;
        m = m + 1;
        if (m == 60) begin
          m = 0;
          h = h + 1;
          if (h == 12)
            n.pm = !t.pm;
          if (h == 13)
            h = 1;
        end
      end
    end
    n.tenths = 4'(tn);
    n.sec = 7'((s / 10) * 16 + s % 10);
    n.min = 7'((m / 10) * 16 + m % 10);
    n.hr = 5'((h / 10) * 16 + h % 10);
    return n;
  endfunction

  task automatic check_byte(input string name, input logic [`CIA_DATA_W-1:0] exp,
                            input logic [`CIA_DATA_W-1:0] act);
    if (exp !== act) begin
      mismatch_count++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_tod(input string name, input cia_tod_t exp, input cia_tod_t act);
    if (exp !== act) begin
      mismatch_count++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      mismatch_count++;
      $display("mismatch %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic write_reg(input cia_reg_e addr, input logic [`CIA_DATA_W-1:0] data);
    @(posedge clk);
    #1;
    cs_n = 1'b0;
    rw = 1'b0;
    rs = addr;
    db_in = data;
    @(posedge clk);
    #1;
    cs_n = 1'b1;
    rw = 1'b1;
    case (addr)
      REG_PRA:  pra_sh = data;
      REG_PRB:  prb_sh = data;
      REG_DDRA: ddra_sh = data;
      REG_DDRB: ddrb_sh = data;
      default: ;
    endcase
  endtask

  task automatic read_reg(input cia_reg_e addr, output logic [`CIA_DATA_W-1:0] data);
    @(posedge clk);
    #1;
    cs_n = 1'b0;
    rw = 1'b1;
    rs = addr;
    @(posedge clk);
    #1;
    cs_n = 1'b1;
    data = db_out;
  endtask

  task automatic wait_phi2();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!phi2 && n < 4);
    #1;
    if (n >= 4 && !phi2) begin
      fail_count++;
      $display("phi2 enable never came high");
    end
  endtask

  task automatic wait_pc_high();
    int n;
    n = 0;
    while (!pc_n && n < 8) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!pc_n) begin
      fail_count++;
      $display("pc_n stayed low after a port B access");
    end
  endtask

  // Counts phi2 cycles until irq_n falls within (lo, hi]
  task automatic wait_irq_low(input string name, input int lo, input int hi);
    int cycles;
    cycles = 0;
    while (irq_n && cycles < hi) begin
      @(posedge clk);
      if (phi2)
        cycles++;
      #1;
    end
    if (irq_n) begin
      fail_count++;
      $display("%s: irq_n did not fall within %0d phi2 cycles", name, hi);
    end else if (cycles <= lo) begin
      fail_count++;
      $display("%s: irq_n fell after %0d phi2 cycles, too early", name, cycles);
    end
  endtask

  task automatic hold_irq_high(input string name, input int cycles);
    int seen;
    seen = 0;
    while (seen < cycles) begin
      @(posedge clk);
      if (phi2)
        seen++;
      #1;
      check_level(name, 1'b1, irq_n);
    end
  endtask

  task automatic tod_pulses(input int count);
    repeat (count) begin
      @(posedge clk);
      #1;
      tod = 1'b1;
      @(posedge clk);
      #1;
      tod = 1'b0;
    end
  endtask

  // Port pins follow the registers one phi2 edge later
  always @(posedge clk) begin : port_monitor
    logic [`CIA_DATA_W-1:0] exp_a;
    logic [`CIA_DATA_W-1:0] exp_b;
    if (!int_reset && phi2) begin
      exp_a = port_model(ddra_sh, pra_sh);
      exp_b = port_model(ddrb_sh, prb_sh);
      #2;
      check_byte("port_a_pins", exp_a, pa_out);
      check_byte("port_b_pins", exp_b, pb_out);
    end
  end

  initial begin : stimulus
    logic [`CIA_DATA_W-1:0] rd;
    logic [`CIA_DATA_W-1:0] data;
    cia_reg_e               addr;
    cia_tod_t               start_t;
    cia_tod_t               now_t;
    cia_tod_t               alarm_t;
    int                     n;

    int_reset = 1'b1;
    phi2 = 1'b0;
    cs_n = 1'b1;
    rw = 1'b1;
    rs = '0;
    db_in = '0;
    pa_in = '0;
    pb_in = '0;
    flag_n = 1'b1;
    tod = 1'b0;
    cnt_in = 1'b0;
    pra_sh = '0;
    prb_sh = '0;
    ddra_sh = '0;
    ddrb_sh = '0;
    mismatch_count = 0;
    fail_count = 0;
    void'($urandom(77));
    repeat (8) @(posedge clk);
    #1;
    int_reset = 1'b0;

    // Ports
    repeat (16) begin
      addr = cia_reg_e'($urandom % 4);
      data = $urandom;
      write_reg(addr, data);
      if (addr == REG_PRB) begin
        check_level("pc_n_low", 1'b0, pc_n);
        wait_pc_high();
      end
      wait_phi2();
    end
    pa_in = $urandom;
    read_reg(REG_PRA, rd);
    check_byte("pra_read", pa_in, rd);

    // Timer A one-shot
    n = 4 + $urandom % 37;
    write_reg(REG_ICR, 8'h81);
    write_reg(REG_TA_LO, n[7:0]);
    write_reg(REG_TA_HI, 8'h00);
    check_level("irq_idle", 1'b1, irq_n);
    write_reg(REG_CRA, 8'h09);
    wait_irq_low("ta_one_shot", n, n + 4);
    read_reg(REG_ICR, rd);
    check_byte("ta_icr", irq_model(5'b00001, 5'b00001), rd);
    check_level("ta_irq_release", 1'b1, irq_n);
    read_reg(REG_CRA, rd);
    check_byte("ta_cra_start", 8'h00, rd & 8'h01);

    // Timer B counts timer A underflows
    n = 4 + $urandom % 13;
    write_reg(REG_ICR, 8'h1F);
    write_reg(REG_ICR, 8'h82);
    write_reg(REG_TA_LO, n[7:0]);
    write_reg(REG_TA_HI, 8'h00);
    write_reg(REG_TB_LO, 8'h02);
    write_reg(REG_TB_HI, 8'h00);
    write_reg(REG_CRB, 8'h49);
    write_reg(REG_CRA, 8'h01);
    wait_irq_low("tb_cascade", 3 * (n + 1), 3 * (n + 3) + 4);
    // Timer A has underflowed unmasked by now
    read_reg(REG_ICR, rd);
    check_byte("tb_icr", irq_model(5'b00011, 5'b00010), rd);
    write_reg(REG_CRA, 8'h00);
    read_reg(REG_ICR, rd);

    // Masked-off underflow
    n = 4 + $urandom % 13;
    write_reg(REG_ICR, 8'h1F);
    write_reg(REG_TA_LO, n[7:0]);
    write_reg(REG_TA_HI, 8'h00);
    write_reg(REG_CRA, 8'h09);
    hold_irq_high("mask_off_irq", n + 6);
    read_reg(REG_ICR, rd);
    check_byte("mask_off_icr", irq_model(5'b00001, 5'b00000), rd);
    read_reg(REG_ICR, rd);
    check_byte("mask_off_clear", irq_model(5'b00000, 5'b00000), rd);

    // TOD rollover through noon flag
    start_t.pm = 1'b1;
    start_t.hr = 5'h11;
    start_t.min = 7'h59;
    start_t.sec = 7'h59;
    start_t.tenths = 4'h9;
    write_reg(REG_TOD_HR, {start_t.pm, 2'b00, start_t.hr});
    write_reg(REG_TOD_MIN, {1'b0, start_t.min});
    write_reg(REG_TOD_SEC, {1'b0, start_t.sec});
    write_reg(REG_TOD_10THS, {4'h0, start_t.tenths});
    tod_pulses(`CIA_TOD_DIV_60);
    read_reg(REG_TOD_HR, rd);
    now_t.pm = rd[7];
    now_t.hr = rd[4:0];
    read_reg(REG_TOD_MIN, rd);
    now_t.min = rd[6:0];
    read_reg(REG_TOD_SEC, rd);
    now_t.sec = rd[6:0];
    read_reg(REG_TOD_10THS, rd);
    now_t.tenths = rd[3:0];
    check_tod("tod_rollover", bcd_advance(start_t), now_t);

    // Alarm one tenth ahead with tenths written first
    alarm_t = bcd_advance(bcd_advance(start_t));
    write_reg(REG_CRB, 8'h80);
    write_reg(REG_TOD_10THS, {4'h0, alarm_t.tenths});
    write_reg(REG_TOD_SEC, {1'b0, alarm_t.sec});
    write_reg(REG_TOD_MIN, {1'b0, alarm_t.min});
    write_reg(REG_TOD_HR, {alarm_t.pm, 2'b00, alarm_t.hr});
    write_reg(REG_CRB, 8'h00);
    read_reg(REG_ICR, rd);
    write_reg(REG_ICR, 8'h84);
    tod_pulses(`CIA_TOD_DIV_60);
    wait_irq_low("tod_alarm", 0, 8);
    read_reg(REG_ICR, rd);
    check_byte("alarm_icr", irq_model(5'b00100, 5'b00100), rd);

    // FLAG falling edge
    write_reg(REG_ICR, 8'h1F);
    write_reg(REG_ICR, 8'h90);
    check_level("flag_idle", 1'b1, irq_n);
    @(posedge clk);
    #1;
    flag_n = 1'b0;
    wait_irq_low("flag_edge", 0, 8);
    read_reg(REG_ICR, rd);
    check_byte("flag_icr", irq_model(5'b10000, 5'b10000), rd);
    check_level("flag_irq_release", 1'b1, irq_n);
    flag_n = 1'b1;
    repeat (4) @(posedge clk);

    $display("errors: mismatch=%0d other=%0d", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+common
common/cia_regs_pkg.sv
common/cia_event_pkg.sv
common/cia_bus_if.sv
source/cia_host_bus.sv
source/cia_port_ctrl.sv
timer/cia_interval_timer.sv
tod/cia_tod_clock.sv
source/cia_irq_ctrl.sv
source/cia_top.sv
verification/cia_tb.sv
